/* boot_rom.sv */
module boot_rom
  import periph_pkg::*;
(
  input  reg_req_t    req_i,
  input  logic        sel_i,
  output periph_rsp_t rsp_o
);

  logic [3:0] word_idx;
  logic       in_range;
  logic       bad_access;

  assign word_idx = req_i.addr[5:2];

  // Only the first 0x40 bytes of the page are backed
  assign in_range = (req_i.addr[11:6] == '0);

  assign bad_access = req_i.write || !in_range;

  // Response held at zero unless selected
  always_comb begin
    rsp_o.rdata = '0;
    rsp_o.error = 1'b0;
    if (sel_i) begin
      if (bad_access) begin
        rsp_o.error = 1'b1;
      end else begin
        rsp_o.rdata = ROM_IMAGE[word_idx];
      end
    end
  end

endmodule

/* clint_timer.sv */
module clint_timer
  import periph_pkg::*;
#(
  parameter int unsigned RTC_SYNC_STAGES = 2
) (
  input  logic        clk_i,
  input  logic        rst_i,

  input  reg_req_t    req_i,
  input  logic        sel_i,
  output periph_rsp_t rsp_o,

  input  logic        rtc_i,
  output logic        timer_irq_o,
  output logic        ipi_o
);

  logic [RTC_SYNC_STAGES-1:0] rtc_sync_q;
  logic                       rtc_prev_q;
  logic                       rtc_edge;

  mtime_t  mtime_q;
  mtime_t  mtimecmp_q;
  logic    msip_q;

  offset_t offs;
  data_t   rdata;
  logic    hit;
  logic    read_only;
  logic    wr_en;

  ////////////////////
  // RTC edge
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rtc_sync_q <= '0;
      rtc_prev_q <= 1'b0;
    end else begin
      rtc_sync_q <= {rtc_sync_q[RTC_SYNC_STAGES-2:0], rtc_i};
      rtc_prev_q <= rtc_sync_q[RTC_SYNC_STAGES-1];
    end
  end

  assign rtc_edge = rtc_sync_q[RTC_SYNC_STAGES-1] && !rtc_prev_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mtime_q <= '0;
    end else if (rtc_edge) begin
      mtime_q <= mtime_q + 64'd1;
    end
  end

  ////////////////////
  // Register access
  ////////////////////

  assign offs  = req_i.addr[11:0];
  assign wr_en = sel_i && req_i.write;

  always_comb begin
    rdata     = '0;
    hit       = 1'b1;
    read_only = 1'b0;
    case (offs)
      CLINT_MSIP:        rdata = {31'b0, msip_q};
      CLINT_MTIMECMP_LO: rdata = mtimecmp_q[31:0];
      CLINT_MTIMECMP_HI: rdata = mtimecmp_q[63:32];
      CLINT_MTIME_LO: begin
        rdata     = mtime_q[31:0];
        read_only = 1'b1;
      end
      CLINT_MTIME_HI: begin
        rdata     = mtime_q[63:32];
        read_only = 1'b1;
      end
      default: hit = 1'b0;
    endcase
  end

  assign rsp_o.rdata = rdata;
  assign rsp_o.error = !hit || (read_only && req_i.write);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      msip_q     <= 1'b0;
      mtimecmp_q <= '1;
    end else if (wr_en) begin
      if (offs == CLINT_MSIP && req_i.wstrb[0]) begin
        msip_q <= req_i.wdata[0];
      end
      if (offs == CLINT_MTIMECMP_LO) begin
        mtimecmp_q[31:0] <= apply_strb(mtimecmp_q[31:0], req_i.wdata, req_i.wstrb);
      end
      if (offs == CLINT_MTIMECMP_HI) begin
        mtimecmp_q[63:32] <= apply_strb(mtimecmp_q[63:32], req_i.wdata, req_i.wstrb);
      end
    end
  end

  assign timer_irq_o = (mtime_q >= mtimecmp_q);
  assign ipi_o       = msip_q;

  assert property (@(posedge clk_i) disable iff (rst_i)
    mtime_q >= $past(mtime_q));

endmodule

/* periph_pkg.sv */
package periph_pkg;

  typedef logic [15:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [11:0] offset_t;
  typedef logic [3:0]  page_t;
  typedef logic [1:0]  boot_mode_t;
  typedef logic [63:0] mtime_t;

  typedef struct packed {
    addr_t addr;
    logic  write;
    data_t wdata;
    strb_t wstrb;
  } reg_req_t;

  typedef struct packed {
    data_t rdata;
    logic  error;
  } reg_rsp_t;

  typedef struct packed {
    data_t rdata;
    logic  error;
  } periph_rsp_t;

  typedef enum logic [1:0] {
    SEL_ROM,
    SEL_CSR,
    SEL_CLINT,
    SEL_NONE
  } page_sel_e;

  ////////////////////
  // Address map
  ////////////////////

  localparam page_t PAGE_ROM   = 4'h0;
  localparam page_t PAGE_CSR   = 4'h1;
  localparam page_t PAGE_CLINT = 4'h2;

  localparam offset_t CSR_ID        = 12'h000;
  localparam offset_t CSR_BOOT_MODE = 12'h004;
  localparam offset_t CSR_FLL_LOCK  = 12'h008;
  localparam offset_t CSR_SCRATCH0  = 12'h00C;
  localparam offset_t CSR_SCRATCH1  = 12'h010;

  localparam offset_t CLINT_MSIP        = 12'h000;
  localparam offset_t CLINT_MTIMECMP_LO = 12'h008;
  localparam offset_t CLINT_MTIMECMP_HI = 12'h00C;
  localparam offset_t CLINT_MTIME_LO    = 12'h010;
  localparam offset_t CLINT_MTIME_HI    = 12'h014;

  localparam data_t SOC_ID = 32'h1c5a_0001;

  localparam int unsigned ROM_WORDS = 16;

  // Small boot stub that spins on wfi after setting up a0/a1
  localparam data_t ROM_IMAGE [ROM_WORDS] = '{
    32'h0000_0297, 32'h0202_8593, 32'hf140_2573, 32'h0182_b283,
    32'h0002_8067, 32'h0000_0013, 32'h1050_0073, 32'hffdf_f06f,
    32'h0010_0513, 32'h0005_1463, 32'h0040_006f, 32'h3040_1073,
    32'h3420_2573, 32'h3000_2073, 32'hdead_beef, 32'hc0de_cafe
  };

  // Byte-wise merge of a write into an existing word
  function automatic data_t apply_strb(data_t old_val, data_t new_val, strb_t strb);
    data_t merged;
    merged = old_val;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        merged[8*i +: 8] = new_val[8*i +: 8];
      end
    end
    return merged;
  endfunction

endpackage

/* periph_subsys.f */
periph_pkg.sv
regbus_decode.sv
boot_rom.sv
soc_csr_file.sv
clint_timer.sv
periph_subsys.sv
tb_periph_subsys.sv

/* periph_subsys.sv */
module periph_subsys
  import periph_pkg::*;
#(
  parameter int unsigned RTC_SYNC_STAGES = 2
) (
  input  logic       clk_i,
  input  logic       rst_i,

  input  reg_req_t   req_i,
  input  logic       req_valid_i,
  output logic       req_ready_o,

  output reg_rsp_t   rsp_o,
  output logic       rsp_valid_o,
  input  logic       rsp_ready_i,

  input  boot_mode_t boot_mode_i,
  input  logic       fll_lock_i,
  input  logic       rtc_i,

  output logic       timer_irq_o,
  output logic       ipi_o
);

  logic        rom_sel, csr_sel, clint_sel;
  periph_rsp_t rom_rsp, csr_rsp, clint_rsp;

  regbus_decode i_regbus_decode (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .req_i       ( req_i       ),
    .req_valid_i ( req_valid_i ),
    .req_ready_o ( req_ready_o ),
    .rsp_o       ( rsp_o       ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_ready_i ( rsp_ready_i ),
    .rom_sel_o   ( rom_sel     ),
    .csr_sel_o   ( csr_sel     ),
    .clint_sel_o ( clint_sel   ),
    .rom_rsp_i   ( rom_rsp     ),
    .csr_rsp_i   ( csr_rsp     ),
    .clint_rsp_i ( clint_rsp   )
  );

  boot_rom i_boot_rom (
    .req_i ( req_i   ),
    .sel_i ( rom_sel ),
    .rsp_o ( rom_rsp )
  );

  soc_csr_file i_soc_csr_file (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .req_i       ( req_i       ),
    .sel_i       ( csr_sel     ),
    .rsp_o       ( csr_rsp     ),
    .boot_mode_i ( boot_mode_i ),
    .fll_lock_i  ( fll_lock_i  )
  );

  clint_timer #(
    .RTC_SYNC_STAGES ( RTC_SYNC_STAGES )
  ) i_clint_timer (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .req_i       ( req_i       ),
    .sel_i       ( clint_sel   ),
    .rsp_o       ( clint_rsp   ),
    .rtc_i       ( rtc_i       ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

endmodule

/* regbus_decode.sv */
module regbus_decode
  import periph_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,

  input  reg_req_t    req_i,
  input  logic        req_valid_i,
  output logic        req_ready_o,

  output reg_rsp_t    rsp_o,
  output logic        rsp_valid_o,
  input  logic        rsp_ready_i,

  output logic        rom_sel_o,
  output logic        csr_sel_o,
  output logic        clint_sel_o,

  input  periph_rsp_t rom_rsp_i,
  input  periph_rsp_t csr_rsp_i,
  input  periph_rsp_t clint_rsp_i
);

  page_sel_e page_sel;
  logic      req_fire;
  reg_rsp_t  rsp_d, rsp_q;
  logic      rsp_valid_q;

  always_comb begin
    case (req_i.addr[15:12])
      PAGE_ROM:   page_sel = SEL_ROM;
      PAGE_CSR:   page_sel = SEL_CSR;
      PAGE_CLINT: page_sel = SEL_CLINT;
      default:    page_sel = SEL_NONE;
    endcase
  end

  // Single outstanding access
  assign req_ready_o = !rsp_valid_q || rsp_ready_i;
  assign req_fire    = req_valid_i && req_ready_o;

  assign rom_sel_o   = req_fire && (page_sel == SEL_ROM);
  assign csr_sel_o   = req_fire && (page_sel == SEL_CSR);
  assign clint_sel_o = req_fire && (page_sel == SEL_CLINT);

  always_comb begin
    rsp_d.rdata = '0;
    rsp_d.error = 1'b1;
    case (page_sel)
      SEL_ROM: begin
        rsp_d.rdata = rom_rsp_i.rdata;
        rsp_d.error = rom_rsp_i.error;
      end
      SEL_CSR: begin
        rsp_d.rdata = csr_rsp_i.rdata;
        rsp_d.error = csr_rsp_i.error;
      end
      SEL_CLINT: begin
        rsp_d.rdata = clint_rsp_i.rdata;
        rsp_d.error = clint_rsp_i.error;
      end
      default: ;
    endcase
  end

  ////////////////////
  // Response register
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_valid_q <= 1'b0;
    end else if (req_fire) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      rsp_q <= rsp_d;
    end
  end

  assign rsp_o       = rsp_q;
  assign rsp_valid_o = rsp_valid_q;

  assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o));

endmodule

/* soc_csr_file.sv */
module soc_csr_file
  import periph_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,

  input  reg_req_t    req_i,
  input  logic        sel_i,
  output periph_rsp_t rsp_o,

  input  boot_mode_t  boot_mode_i,
  input  logic        fll_lock_i
);

  offset_t    offs;
  data_t      rdata;
  logic       hit;
  logic       read_only;
  logic [1:0] scratch_we;
  data_t      scratch_q [2];

  assign offs = req_i.addr[11:0];

  always_comb begin
    rdata     = '0;
    hit       = 1'b1;
    read_only = 1'b0;
    case (offs)
      CSR_ID: begin
        rdata     = SOC_ID;
        read_only = 1'b1;
      end
      CSR_BOOT_MODE: begin
        rdata     = {30'b0, boot_mode_i};
        read_only = 1'b1;
      end
      CSR_FLL_LOCK: begin
        rdata     = {31'b0, fll_lock_i};
        read_only = 1'b1;
      end
      CSR_SCRATCH0: rdata = scratch_q[0];
      CSR_SCRATCH1: rdata = scratch_q[1];
      default:      hit = 1'b0;
    endcase
  end

  assign rsp_o.rdata = rdata;
  assign rsp_o.error = !hit || (read_only && req_i.write);

  assign scratch_we[0] = sel_i && req_i.write && (offs == CSR_SCRATCH0);
  assign scratch_we[1] = sel_i && req_i.write && (offs == CSR_SCRATCH1);

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < 2; i++) begin
      if (rst_i) begin
        scratch_q[i] <= '0;
      end else if (scratch_we[i]) begin
        scratch_q[i] <= apply_strb(scratch_q[i], req_i.wdata, req_i.wstrb);
      end
    end
  end

endmodule

/* tb_periph_subsys.sv */
module tb_periph_subsys
  import periph_pkg::*;
();

  localparam int WAIT_LIMIT = 50;
  localparam int POLL_LIMIT = 20;

  typedef struct packed {
    logic  check;
    logic  check_data;
    data_t rdata;
    logic  error;
  } exp_t;

  logic       clk_i;
  logic       rst_i;
  reg_req_t   req_i;
  logic       req_valid_i;
  logic       req_ready_o;
  reg_rsp_t   rsp_o;
  logic       rsp_valid_o;
  logic       rsp_ready_i;
  boot_mode_t boot_mode_i;
  logic       fll_lock_i;
  logic       rtc_i;
  logic       timer_irq_o;
  logic       ipi_o;

  logic [31:0] lfsr_q = 32'hb00a;
  exp_t        exp_q [$];
  int          check_count = 0;
  int          error_count = 0;
  int          other_fails = 0;

  // Testbench model of the peripheral state
  data_t  scratch_m [2] = '{32'h0, 32'h0};
  logic   msip_m        = 1'b0;
  mtime_t mtimecmp_m    = '1;
  mtime_t pulse_count   = '0;

  periph_subsys #(
    .RTC_SYNC_STAGES ( 2 )
  ) dut0 (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .req_i       ( req_i       ),
    .req_valid_i ( req_valid_i ),
    .req_ready_o ( req_ready_o ),
    .rsp_o       ( rsp_o       ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_ready_i ( rsp_ready_i ),
    .boot_mode_i ( boot_mode_i ),
    .fll_lock_i  ( fll_lock_i  ),
    .rtc_i       ( rtc_i       ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  ////////////////////
  // Random numbers
  ////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output data_t val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val    = {val[30:0], lfsr_q[0]};
    end
  endtask

  ////////////////////
  // Reference model
  ////////////////////

  function automatic data_t merge_bytes(data_t old_v, data_t new_v, strb_t strb);
    data_t mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_v & ~mask) | (new_v & mask);
  endfunction

  function automatic exp_t expected_rsp(reg_req_t req);
    exp_t    e;
    offset_t offs;
    offs         = req.addr[11:0];
    e.check      = 1'b1;
    e.check_data = !req.write;
    e.rdata      = '0;
    e.error      = 1'b0;
    case (req.addr[15:12])
      PAGE_ROM: begin
        if (req.write || offs >= 12'h040) begin
          e.error      = 1'b1;
          e.check_data = 1'b1;
        end else begin
          e.rdata = ROM_IMAGE[offs[5:2]];
        end
      end
      PAGE_CSR: begin
        case (offs)
          CSR_ID:        e.rdata = SOC_ID;
          CSR_BOOT_MODE: e.rdata = {30'b0, boot_mode_i};
          CSR_FLL_LOCK:  e.rdata = {31'b0, fll_lock_i};
          CSR_SCRATCH0:  e.rdata = scratch_m[0];
          CSR_SCRATCH1:  e.rdata = scratch_m[1];
          default:       e.error = 1'b1;
        endcase
        if (req.write && offs inside {CSR_ID, CSR_BOOT_MODE, CSR_FLL_LOCK}) begin
          e.error = 1'b1;
        end
      end
      PAGE_CLINT: begin
        case (offs)
          CLINT_MSIP:        e.rdata = {31'b0, msip_m};
          CLINT_MTIMECMP_LO: e.rdata = mtimecmp_m[31:0];
          CLINT_MTIMECMP_HI: e.rdata = mtimecmp_m[63:32];
          CLINT_MTIME_LO:    e.rdata = pulse_count[31:0];
          CLINT_MTIME_HI:    e.rdata = pulse_count[63:32];
          default:           e.error = 1'b1;
        endcase
        if (req.write && offs inside {CLINT_MTIME_LO, CLINT_MTIME_HI}) begin
          e.error = 1'b1;
        end
      end
      default: begin
        e.error      = 1'b1;
        e.check_data = 1'b1;
      end
    endcase
    return e;
  endfunction

  task automatic model_write(input reg_req_t req);
    exp_t e;
    e = expected_rsp(req);
    if (req.write && !e.error) begin
      if (req.addr[15:12] == PAGE_CSR) begin
        if (req.addr[11:0] == CSR_SCRATCH0) begin
          scratch_m[0] = merge_bytes(scratch_m[0], req.wdata, req.wstrb);
        end else begin
          scratch_m[1] = merge_bytes(scratch_m[1], req.wdata, req.wstrb);
        end
      end else if (req.addr[11:0] == CLINT_MSIP) begin
        if (req.wstrb[0]) begin
          msip_m = req.wdata[0];
        end
      end else if (req.addr[11:0] == CLINT_MTIMECMP_LO) begin
        mtimecmp_m[31:0] = merge_bytes(mtimecmp_m[31:0], req.wdata, req.wstrb);
      end else begin
        mtimecmp_m[63:32] = merge_bytes(mtimecmp_m[63:32], req.wdata, req.wstrb);
      end
    end
  endtask

  task automatic check_value(input string name, input data_t got, input data_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("ERROR: %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
    end
  endtask

  // Compares every response that transfers with the oldest expected entry
  always @(negedge clk_i) begin : compare_rsp
    exp_t e;
    if (!rst_i && rsp_valid_o && rsp_ready_i) begin
      if (exp_q.size() == 0) begin
        other_fails++;
        $display("A response transferred with no request pending at %0t", $time);
      end else begin
        e = exp_q.pop_front();
        if (e.check) begin
          if (e.check_data) begin
            check_value("rsp_o.rdata", rsp_o.rdata, e.rdata);
          end
          check_value("rsp_o.error", rsp_o.error, e.error);
        end
      end
    end
  end

  ////////////////////
  // Bus tasks
  ////////////////////

  // Called and returns 1 time unit after a rising edge
  task automatic issue_access(input reg_req_t req, input int hold, input logic check,
                              output reg_rsp_t rsp);
    exp_t e;
    int   cnt;
    e           = expected_rsp(req);
    e.check     = check;
    rsp         = '0;
    req_i       = req;
    req_valid_i = 1'b1;
    rsp_ready_i = (hold == 0);
    cnt         = 0;
    while (!req_ready_o && cnt < WAIT_LIMIT) begin
      @(posedge clk_i);
      #1;
      cnt++;
    end
    if (!req_ready_o) begin
      other_fails++;
      $display("Request to 0x%04h was never accepted", req.addr);
      req_valid_i = 1'b0;
      return;
    end
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b0;
    exp_q.push_back(e);
    model_write(req);
    cnt = 0;
    while (!rsp_valid_o && cnt < WAIT_LIMIT) begin
      @(posedge clk_i);
      #1;
      cnt++;
    end
    if (!rsp_valid_o) begin
      other_fails++;
      $display("No response came for the request to 0x%04h", req.addr);
      exp_q.delete();
      rsp_ready_i = 1'b0;
      return;
    end
    check_value("response latency", cnt, 0);
    // Response must stay put while the master stalls
    for (int i = 0; i < hold; i++) begin
      check_value("req_ready_o", req_ready_o, 1'b0);
      if (e.check && e.check_data) begin
        check_value("rsp_o.rdata", rsp_o.rdata, e.rdata);
      end
      if (e.check) begin
        check_value("rsp_o.error", rsp_o.error, e.error);
      end
      @(posedge clk_i);
      #1;
    end
    rsp         = rsp_o;
    rsp_ready_i = 1'b1;
    @(posedge clk_i);
    #1;
    rsp_ready_i = 1'b0;
  endtask

  task automatic write_reg(input addr_t addr, input data_t data, input strb_t strb);
    reg_rsp_t rsp;
    issue_access('{addr: addr, write: 1'b1, wdata: data, wstrb: strb}, 0, 1'b1, rsp);
  endtask

  task automatic read_reg(input addr_t addr, input logic stall, input logic check,
                          output data_t data);
    reg_rsp_t rsp;
    data_t    hold;
    hold = '0;
    if (stall) begin
      rand_bits(3, hold);
      hold = hold + 1;
    end
    issue_access('{addr: addr, write: 1'b0, wdata: '0, wstrb: '0}, hold, check, rsp);
    data = rsp.rdata;
  endtask

  task automatic rtc_pulse();
    rtc_i = 1'b1;
    repeat (6) @(posedge clk_i);
    #1;
    rtc_i = 1'b0;
    pulse_count++;
    repeat (6) @(posedge clk_i);
    #1;
  endtask

  task automatic wait_mtime(input data_t count);
    data_t d;
    int    cnt;
    d   = '1;
    cnt = 0;
    while (d != count && cnt < POLL_LIMIT) begin
      read_reg({PAGE_CLINT, CLINT_MTIME_LO}, 1'b0, 1'b0, d);
      cnt++;
    end
    if (d != count) begin
      other_fails++;
      $display("mtime never reached %0d", count);
    end
  endtask

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    data_t d;
    data_t wd;
    data_t strb;
    data_t n;
    req_i       = '0;
    req_valid_i = 1'b0;
    rsp_ready_i = 1'b0;
    boot_mode_i = '0;
    fll_lock_i  = 1'b0;
    rtc_i       = 1'b0;
    rst_i       = 1'b1;
    repeat (3) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    check_value("req_ready_o", req_ready_o, 1'b1);
    check_value("rsp_valid_o", rsp_valid_o, 1'b0);
    check_value("timer_irq_o", timer_irq_o, 1'b0);
    check_value("ipi_o", ipi_o, 1'b0);

    // Boot ROM
    for (int i = 0; i < ROM_WORDS; i++) begin
      read_reg(16'h0000 + 16'(4 * i), 1'b0, 1'b1, d);
    end
    write_reg(16'h0008, 32'h1234_5678, 4'hf);
    read_reg(16'h0040, 1'b0, 1'b1, d);

    // CSR file
    read_reg({PAGE_CSR, CSR_ID}, 1'b0, 1'b1, d);
    for (int v = 0; v < 4; v++) begin
      boot_mode_i = v[1:0];
      fll_lock_i  = v[0];
      read_reg({PAGE_CSR, CSR_BOOT_MODE}, 1'b0, 1'b1, d);
      read_reg({PAGE_CSR, CSR_FLL_LOCK}, 1'b0, 1'b1, d);
    end
    for (int i = 0; i < 8; i++) begin
      rand_bits(32, wd);
      rand_bits(4, strb);
      write_reg({PAGE_CSR, (i[0] ? CSR_SCRATCH1 : CSR_SCRATCH0)}, wd, strb[3:0]);
      read_reg({PAGE_CSR, (i[0] ? CSR_SCRATCH1 : CSR_SCRATCH0)}, 1'b0, 1'b1, d);
    end
    write_reg({PAGE_CSR, CSR_ID}, 32'hffff_ffff, 4'hf);

    // Unmapped pages leave the scratch registers alone
    for (int i = 0; i < 4; i++) begin
      rand_bits(4, n);
      if (n < 3) begin
        n = n + 3;
      end
      write_reg({n[3:0], CSR_SCRATCH0}, 32'h5a5a_5a5a, 4'hf);
      read_reg({n[3:0], CSR_SCRATCH0}, 1'b0, 1'b1, d);
    end
    read_reg({PAGE_CSR, CSR_SCRATCH0}, 1'b0, 1'b1, d);

    // Back-pressure
    for (int i = 0; i < 6; i++) begin
      read_reg(16'h0000 + 16'(4 * i), 1'b1, 1'b1, d);
      read_reg({PAGE_CSR, CSR_SCRATCH1}, 1'b1, 1'b1, d);
    end

    // Software interrupt
    write_reg({PAGE_CLINT, CLINT_MSIP}, 32'h1, 4'h1);
    check_value("ipi_o", ipi_o, 1'b1);
    read_reg({PAGE_CLINT, CLINT_MSIP}, 1'b0, 1'b1, d);
    write_reg({PAGE_CLINT, CLINT_MSIP}, 32'h0, 4'h1);
    check_value("ipi_o", ipi_o, 1'b0);

    // Timer compare at a small random count
    rand_bits(3, n);
    n = n + 1;
    write_reg({PAGE_CLINT, CLINT_MTIMECMP_HI}, 32'h0, 4'hf);
    write_reg({PAGE_CLINT, CLINT_MTIMECMP_LO}, n, 4'hf);
    read_reg({PAGE_CLINT, CLINT_MTIMECMP_LO}, 1'b0, 1'b1, d);
    read_reg({PAGE_CLINT, CLINT_MTIMECMP_HI}, 1'b0, 1'b1, d);
    check_value("timer_irq_o", timer_irq_o, 1'b0);
    for (int k = 1; k <= n; k++) begin
      rtc_pulse();
      wait_mtime(k);
      check_value("timer_irq_o", timer_irq_o, (k >= n));
    end
    read_reg({PAGE_CLINT, CLINT_MTIME_LO}, 1'b0, 1'b1, d);
    read_reg({PAGE_CLINT, CLINT_MTIME_HI}, 1'b0, 1'b1, d);
    write_reg({PAGE_CLINT, CLINT_MTIME_LO}, 32'h0, 4'hf);
    read_reg({PAGE_CLINT, 12'h018}, 1'b0, 1'b1, d);

    if (exp_q.size() != 0) begin
      other_fails++;
      $display("%0d responses never arrived", exp_q.size());
    end
    $display("Checks: %0d, value errors: %0d, other failures: %0d",
             check_count, error_count, other_fails);
    if (error_count == 0 && other_fails == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
